// ==== design/arm_pkg.sv ====
package arm_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// register number, 15 is the pc
	typedef logic [3:0] reg_idx_t;

	// N, Z, C, V as in cpsr bits 31 to 28
	typedef logic [3:0] flags_t;

	typedef logic [3:0] cond_t;

	// bit positions inside flags_t
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	typedef enum logic [3:0] {
		OP_AND = 4'h0,
		OP_EOR = 4'h1,
		OP_SUB = 4'h2,
		OP_RSB = 4'h3,
		OP_ADD = 4'h4,
		OP_ADC = 4'h5,
		OP_SBC = 4'h6,
		OP_RSC = 4'h7,
		OP_TST = 4'h8,
		OP_TEQ = 4'h9,
		OP_CMP = 4'ha,
		OP_CMN = 4'hb,
		OP_ORR = 4'hc,
		OP_MOV = 4'hd,
		OP_BIC = 4'he,
		OP_MVN = 4'hf
	} dp_op_e;

	typedef enum logic [1:0] {
		SH_LSL = 2'b00,
		SH_LSR = 2'b01,
		SH_ASR = 2'b10,
		SH_ROR = 2'b11
	} shift_e;

	typedef enum logic [1:0] {
		SEQ_INIT    = 2'd0,
		SEQ_FETCH   = 2'd1,
		SEQ_EXECUTE = 2'd2
	} seq_state_e;

	// r15 reads two instructions ahead
	localparam word_t PC_READ_OFFSET = 32'd8;
	localparam word_t INSTR_STEP = 32'd4;

endpackage

// ==== design/arm_shifter_alu.sv ====
`timescale 1ns/1ps

module arm_shifter_alu (
	input  arm_pkg::dp_op_e op,
	input  arm_pkg::word_t  rn_val,
	input  arm_pkg::word_t  rm_val,
	input  logic            imm_sel,
	input  logic [7:0]      imm8,
	input  logic [3:0]      rot,
	input  logic [4:0]      shift_amt,
	input  arm_pkg::shift_e shift_type,
	input  arm_pkg::flags_t flags,
	output arm_pkg::word_t  result,
	output arm_pkg::flags_t flags_out,
	output logic            writes_rd
);
	import arm_pkg::*;

	word_t shop; // shifter operand
	logic shc;   // shifter carry out
	logic [63:0] rot_wide;
	logic [32:0] ext;
	word_t add_a;
	word_t add_b;
	logic add_cin;
	logic arith;
	logic [32:0] sum;
	word_t logic_res;
	logic c_in;

	assign c_in = flags[FLAG_C];

	always_comb begin
		rot_wide = '0;
		ext = '0;
		shop = rm_val;
		shc = c_in;
		if (imm_sel) begin
			rot_wide = {24'd0, imm8, 24'd0, imm8} >> {rot, 1'b0};
			shop = rot_wide[31:0];
			shc = (rot == 4'd0) ? c_in : shop[31];
		end else begin
			case (shift_type)
				SH_LSL: if (shift_amt != 5'd0) begin
					ext = {1'b0, rm_val} << shift_amt;
					shop = ext[31:0];
					shc = ext[32];
				end
				SH_LSR: if (shift_amt == 5'd0) begin // #0 means #32
					shop = '0;
					shc = rm_val[31];
				end else begin
					ext = {rm_val, 1'b0} >> shift_amt;
					shop = ext[32:1];
					shc = ext[0];
				end
				SH_ASR: if (shift_amt == 5'd0) begin
					shop = {32{rm_val[31]}};
					shc = rm_val[31];
				end else begin
					ext = $signed({rm_val, 1'b0}) >>> shift_amt;
					shop = ext[32:1];
					shc = ext[0];
				end
				SH_ROR: if (shift_amt == 5'd0) begin // rrx
					shop = {c_in, rm_val[31:1]};
					shc = rm_val[0];
				end else begin
					rot_wide = {rm_val, rm_val} >> shift_amt;
					shop = rot_wide[31:0];
					shc = shop[31];
				end
			endcase
		end
	end

	// subtraction is a + ~b + 1, so C is the inverted borrow
	always_comb begin
		add_a = rn_val;
		add_b = shop;
		add_cin = 1'b0;
		case (op)
			OP_SUB, OP_CMP: begin
				add_b = ~shop;
				add_cin = 1'b1;
			end
			OP_RSB: begin
				add_a = shop;
				add_b = ~rn_val;
				add_cin = 1'b1;
			end
			OP_ADC: add_cin = c_in;
			OP_SBC: begin
				add_b = ~shop;
				add_cin = c_in;
			end
			OP_RSC: begin
				add_a = shop;
				add_b = ~rn_val;
				add_cin = c_in;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		case (op)
			OP_AND, OP_TST: logic_res = rn_val & shop;
			OP_EOR, OP_TEQ: logic_res = rn_val ^ shop;
			OP_ORR: logic_res = rn_val | shop;
			OP_BIC: logic_res = rn_val & ~shop;
			OP_MVN: logic_res = ~shop;
			default: logic_res = shop; // mov
		endcase
	end

	assign arith = op inside {OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC, OP_CMP, OP_CMN};
	assign sum = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};
	assign result = arith ? sum[31:0] : logic_res;

	assign flags_out[FLAG_N] = result[31];
	assign flags_out[FLAG_Z] = (result == '0);
	assign flags_out[FLAG_C] = arith ? sum[32] : shc;
	assign flags_out[FLAG_V] = arith ? (add_a[31] == add_b[31]) && (sum[31] != add_a[31])
		: flags[FLAG_V];

	assign writes_rd = !(op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});

endmodule

// ==== design/arm_execute.sv ====
`timescale 1ns/1ps

module arm_execute (
	input  arm_pkg::word_t    instr,
	input  logic              commit,
	input  arm_pkg::word_t    pc,
	input  arm_pkg::flags_t   flags,
	output arm_pkg::reg_idx_t rd_a_idx,
	output arm_pkg::reg_idx_t rd_b_idx,
	output arm_pkg::reg_idx_t rd_c_idx,
	input  arm_pkg::word_t    rd_a_data,
	input  arm_pkg::word_t    rd_b_data,
	input  arm_pkg::word_t    rd_c_data,
	input  arm_pkg::word_t    mem_rdata,
	output logic              ex_mem_read,
	output logic              ex_mem_write,
	output arm_pkg::word_t    ex_addr,
	output arm_pkg::word_t    ex_wdata,
	output logic              wr0_en,
	output arm_pkg::reg_idx_t wr0_idx,
	output arm_pkg::word_t    wr0_data,
	output logic              wr1_en,
	output arm_pkg::reg_idx_t wr1_idx,
	output arm_pkg::word_t    wr1_data,
	output logic              pc_en,
	output arm_pkg::word_t    pc_next,
	output logic              flags_en,
	output arm_pkg::flags_t   flags_next
);
	import arm_pkg::*;

	cond_t cond;
	logic pass;
	logic n, z, c, v;
	logic is_dp, is_br, is_ls;
	logic s_bit;
	logic ls_pre, ls_up, ls_wb, ls_load;
	reg_idx_t rn, rd;
	word_t offs_addr, seq_pc, br_target, alu_res;
	logic alu_wr;

	assign cond = instr[31:28];
	assign n = flags[FLAG_N];
	assign z = flags[FLAG_Z];
	assign c = flags[FLAG_C];
	assign v = flags[FLAG_V];

	always_comb begin
		case (cond)
			4'h0: pass = z;
			4'h1: pass = !z;
			4'h2: pass = c;
			4'h3: pass = !c;
			4'h4: pass = n;
			4'h5: pass = !n;
			4'h6: pass = v;
			4'h7: pass = !v;
			4'h8: pass = c && !z;
			4'h9: pass = !c || z;
			4'ha: pass = (n == v);
			4'hb: pass = (n != v);
			4'hc: pass = !z && (n == v);
			4'hd: pass = z || (n != v);
			4'he: pass = 1'b1;
			default: pass = 1'b0; // nv
		endcase
	end

	assign rn = instr[19:16];
	assign rd = instr[15:12];
	assign s_bit = instr[20];

	// compares without S are the misc space, register shifts are not handled
	assign is_dp = (instr[27:26] == 2'b00) && (instr[25] || !instr[4])
		&& !(instr[24:23] == 2'b10 && !s_bit);
	assign is_br = (instr[27:25] == 3'b101);
	assign is_ls = (instr[27:25] == 3'b010) && !instr[22]; // word, immediate offset

	assign rd_a_idx = rn;
	assign rd_b_idx = instr[3:0];
	assign rd_c_idx = rd; // store data

	arm_shifter_alu u_alu (
		.op        (dp_op_e'(instr[24:21])),
		.rn_val    (rd_a_data),
		.rm_val    (rd_b_data),
		.imm_sel   (instr[25]),
		.imm8      (instr[7:0]),
		.rot       (instr[11:8]),
		.shift_amt (instr[11:7]),
		.shift_type(shift_e'(instr[6:5])),
		.flags     (flags),
		.result    (alu_res),
		.flags_out (flags_next),
		.writes_rd (alu_wr)
	);

	assign ls_pre = instr[24];
	assign ls_up = instr[23];
	assign ls_wb = !ls_pre || instr[21]; // post-index always writes back
	assign ls_load = instr[20];
	assign offs_addr = ls_up ? rd_a_data + {20'd0, instr[11:0]}
		: rd_a_data - {20'd0, instr[11:0]};

	assign ex_addr = ls_pre ? offs_addr : rd_a_data;
	assign ex_wdata = rd_c_data;
	assign ex_mem_read = is_ls && pass && ls_load;
	assign ex_mem_write = is_ls && pass && !ls_load;

	assign seq_pc = pc + INSTR_STEP;
	assign br_target = pc + PC_READ_OFFSET + {{6{instr[23]}}, instr[23:0], 2'b00};

	always_comb begin
		wr0_en = 1'b0;
		wr0_idx = rd;
		wr0_data = alu_res;
		wr1_en = 1'b0;
		wr1_idx = rn;
		wr1_data = offs_addr;
		pc_next = seq_pc;
		flags_en = 1'b0;
		if (commit && pass) begin
			if (is_dp) begin
				wr0_en = alu_wr;
				flags_en = s_bit && (rd != 4'd15); // no spsr to restore
			end else if (is_br) begin
				pc_next = br_target;
				wr1_en = instr[24]; // bl link
				wr1_idx = 4'd14;
				wr1_data = seq_pc;
			end else if (is_ls) begin
				wr0_en = ls_load;
				wr0_data = mem_rdata;
				// loaded value wins over write-back to the same base
				wr1_en = ls_wb && !(ls_load && rn == rd);
			end
		end
	end

	assign pc_en = commit;

endmodule

// ==== design/arm_regfile.sv ====
`timescale 1ns/1ps

module arm_regfile #(
	parameter arm_pkg::word_t RESET_PC = 32'h0800_0000
) (
	input  logic              clk,
	input  logic              rstn,
	input  arm_pkg::reg_idx_t rd_a_idx,
	input  arm_pkg::reg_idx_t rd_b_idx,
	input  arm_pkg::reg_idx_t rd_c_idx,
	output arm_pkg::word_t    rd_a_data,
	output arm_pkg::word_t    rd_b_data,
	output arm_pkg::word_t    rd_c_data,
	input  logic              wr0_en,
	input  logic              wr1_en,
	input  arm_pkg::reg_idx_t wr0_idx,
	input  arm_pkg::reg_idx_t wr1_idx,
	input  arm_pkg::word_t    wr0_data,
	input  arm_pkg::word_t    wr1_data,
	input  logic              pc_en,
	input  logic              init_pc,
	input  arm_pkg::word_t    pc_next,
	output arm_pkg::word_t    pc,
	input  logic              flags_en,
	input  arm_pkg::flags_t   flags_next,
	output arm_pkg::flags_t   flags
);
	import arm_pkg::*;

	word_t gpr [0:14]; // r0 to r14
	logic wr0_pc;
	logic wr1_pc;

	function automatic word_t read_port(input reg_idx_t idx);
		return (idx == 4'd15) ? pc + PC_READ_OFFSET : gpr[idx];
	endfunction

	always_comb begin
		rd_a_data = read_port(rd_a_idx);
		rd_b_data = read_port(rd_b_idx);
		rd_c_data = read_port(rd_c_idx);
	end

	assign wr0_pc = wr0_en && (wr0_idx == 4'd15);
	assign wr1_pc = wr1_en && (wr1_idx == 4'd15);

	always_ff @(posedge clk) begin
		if (wr0_en && !wr0_pc)
			gpr[wr0_idx] <= wr0_data;
		if (wr1_en && !wr1_pc)
			gpr[wr1_idx] <= wr1_data;
	end

	// explicit r15 writes beat the sequential next pc
	always_ff @(posedge clk) begin
		if (!rstn || init_pc)
			pc <= RESET_PC;
		else if (wr0_pc)
			pc <= wr0_data;
		else if (wr1_pc)
			pc <= wr1_data;
		else if (pc_en)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			flags <= '0;
		else if (flags_en)
			flags <= flags_next;
	end

	a_wr_distinct: assert property (@(posedge clk) disable iff (!rstn)
		wr0_en && wr1_en |-> wr0_idx != wr1_idx);

endmodule

// ==== design/arm_sequencer.sv ====
`timescale 1ns/1ps

module arm_sequencer #(
	parameter arm_pkg::word_t RESET_PC = 32'h0800_0000
) (
	input  logic           clk,
	input  logic           rstn,
	input  arm_pkg::word_t pc,
	input  logic           ex_mem_read,
	input  logic           ex_mem_write,
	input  arm_pkg::word_t ex_addr,
	input  arm_pkg::word_t ex_wdata,
	output arm_pkg::word_t mem_addr,
	output arm_pkg::word_t mem_wdata,
	input  arm_pkg::word_t mem_rdata,
	output logic           mem_read,
	output logic           mem_write,
	input  logic           mem_ok,
	output arm_pkg::word_t instr,
	output logic           init_pc,
	output logic           commit
);
	import arm_pkg::*;

	seq_state_e state;
	seq_state_e state_next;
	logic data_req; // execute wants the bus

	assign data_req = ex_mem_read | ex_mem_write;

	always_ff @(posedge clk) begin
		if (!rstn)
			state <= SEQ_INIT;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			SEQ_INIT: state_next = SEQ_FETCH;
			SEQ_FETCH: if (mem_ok) state_next = SEQ_EXECUTE;
			SEQ_EXECUTE: if (commit) state_next = SEQ_FETCH;
			default: state_next = SEQ_INIT;
		endcase
	end

	// instruction register, loaded when the fetch completes
	always_ff @(posedge clk) begin
		if (state == SEQ_FETCH && mem_ok)
			instr <= mem_rdata;
	end

	assign init_pc = (state == SEQ_INIT);
	assign commit = (state == SEQ_EXECUTE) && (!data_req || mem_ok); // waits on data access

	// fetch uses the pc, execute hands the port to the data access
	assign mem_addr = (state == SEQ_EXECUTE) ? ex_addr : pc;
	assign mem_wdata = ex_wdata;
	assign mem_read = (state == SEQ_FETCH) || (state == SEQ_EXECUTE && ex_mem_read);
	assign mem_write = (state == SEQ_EXECUTE) && ex_mem_write;

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(mem_read && mem_write));

	// a waiting request keeps its address
	a_addr_hold: assert property (@(posedge clk) disable iff (!rstn)
		(mem_read || mem_write) && !mem_ok |=> $stable(mem_addr));

endmodule

// ==== design/arm_core.sv ====
`timescale 1ns/1ps

module arm_core #(
	parameter arm_pkg::word_t RESET_PC = 32'h0800_0000
) (
	input  logic           clk,
	input  logic           rstn,
	output arm_pkg::word_t mem_addr,
	output arm_pkg::word_t mem_wdata,
	input  arm_pkg::word_t mem_rdata,
	output logic           mem_read,
	output logic           mem_write,
	input  logic           mem_ok
);
	import arm_pkg::*;

	word_t pc, instr;
	word_t ex_addr, ex_wdata;
	logic ex_mem_read, ex_mem_write;
	logic init_pc, commit;

	reg_idx_t rd_a_idx, rd_b_idx, rd_c_idx;
	word_t rd_a_data, rd_b_data, rd_c_data;

	logic wr0_en, wr1_en;
	reg_idx_t wr0_idx, wr1_idx;
	word_t wr0_data, wr1_data;
	logic pc_en, flags_en;
	word_t pc_next;
	flags_t flags, flags_next;

	// fetches and owns the bus
	arm_sequencer #(.RESET_PC(RESET_PC)) u_seq (
		.clk         (clk),
		.rstn        (rstn),
		.pc          (pc),
		.ex_mem_read (ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_addr     (ex_addr),
		.ex_wdata    (ex_wdata),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_ok      (mem_ok),
		.instr       (instr),
		.init_pc     (init_pc),
		.commit      (commit)
	);

	arm_regfile #(.RESET_PC(RESET_PC)) u_regs (
		.clk       (clk),
		.rstn      (rstn),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_c_idx  (rd_c_idx),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.rd_c_data (rd_c_data),
		.wr0_en    (wr0_en),
		.wr1_en    (wr1_en),
		.wr0_idx   (wr0_idx),
		.wr1_idx   (wr1_idx),
		.wr0_data  (wr0_data),
		.wr1_data  (wr1_data),
		.pc_en     (pc_en),
		.init_pc   (init_pc),
		.pc_next   (pc_next),
		.pc        (pc),
		.flags_en  (flags_en),
		.flags_next(flags_next),
		.flags     (flags)
	);

	arm_execute u_exec (
		.instr       (instr),
		.commit      (commit),
		.pc          (pc),
		.flags       (flags),
		.rd_a_idx    (rd_a_idx),
		.rd_b_idx    (rd_b_idx),
		.rd_c_idx    (rd_c_idx),
		.rd_a_data   (rd_a_data),
		.rd_b_data   (rd_b_data),
		.rd_c_data   (rd_c_data),
		.mem_rdata   (mem_rdata),
		.ex_mem_read (ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.ex_addr     (ex_addr),
		.ex_wdata    (ex_wdata),
		.wr0_en      (wr0_en),
		.wr0_idx     (wr0_idx),
		.wr0_data    (wr0_data),
		.wr1_en      (wr1_en),
		.wr1_idx     (wr1_idx),
		.wr1_data    (wr1_data),
		.pc_en       (pc_en),
		.pc_next     (pc_next),
		.flags_en    (flags_en),
		.flags_next  (flags_next)
	);

endmodule

// ==== include/arm_ref_model.svh ====
`ifndef ARM_REF_MODEL_SVH
`define ARM_REF_MODEL_SVH

// instruction-set model, include where arm_pkg is imported

typedef struct {
	word_t  r [16]; // r[15] is the address of the current instruction
	flags_t nzcv;
} ref_state_t;

// data access an instruction makes
typedef struct {
	logic  rd;
	logic  wr;
	word_t addr;
	word_t wdata;
} ref_access_t;

function automatic word_t ref_reg(input ref_state_t st, input reg_idx_t i);
	return (i == 4'd15) ? st.r[15] + PC_READ_OFFSET : st.r[i];
endfunction

// odd codes negate the even one below, AL passes, NV never
function automatic logic ref_cond(input cond_t cc, input flags_t f);
	logic n, z, c, v, p;
	{n, z, c, v} = f;
	case (cc[3:1])
		3'd0: p = z;
		3'd1: p = c;
		3'd2: p = n;
		3'd3: p = v;
		3'd4: p = c & ~z;
		3'd5: p = (n == v);
		3'd6: p = ~z & (n == v);
		default: p = 1'b1;
	endcase
	return (cc == 4'hf) ? 1'b0 : p ^ (cc[0] & (cc[3:1] != 3'd7));
endfunction

// steps st by one instruction, ld_data is the word at the load address
function automatic ref_access_t ref_step(inout ref_state_t st, input word_t instr,
		input word_t ld_data);
	ref_access_t acc;
	word_t a, m, d, op2, res, x, y, addr, nxt;
	logic c, sc, cin, arith;
	logic [32:0] sum;
	int amt;
	dp_op_e op;
	reg_idx_t rn, rd;

	acc = '{rd: 1'b0, wr: 1'b0, addr: '0, wdata: '0};
	rn = instr[19:16];
	rd = instr[15:12];
	op = dp_op_e'(instr[24:21]);
	a = ref_reg(st, rn);
	m = ref_reg(st, instr[3:0]);
	d = ref_reg(st, rd);
	c = st.nzcv[1];
	nxt = st.r[15] + INSTR_STEP;
	if (!ref_cond(instr[31:28], st.nzcv)) begin
		st.r[15] = nxt;
		return acc;
	end
	if (instr[27:25] == 3'b101) begin
		if (instr[24])
			st.r[14] = nxt;
		st.r[15] = st.r[15] + PC_READ_OFFSET + {{6{instr[23]}}, instr[23:0], 2'b00};
		return acc;
	end
	st.r[15] = nxt;
	if (instr[27:25] == 3'b010 && !instr[22]) begin
		addr = instr[23] ? a + instr[11:0] : a - instr[11:0];
		acc.rd = instr[20];
		acc.wr = !instr[20];
		acc.addr = instr[24] ? addr : a;
		acc.wdata = d;
		if (!instr[24] || instr[21])
			st.r[rn] = addr;
		if (instr[20])
			st.r[rd] = ld_data; // overrides a write-back to the same register
		return acc;
	end
	if (instr[27:26] != 2'b00 || (!instr[25] && instr[4])
			|| (instr[24:23] == 2'b10 && !instr[20]))
		return acc; // outside the subset
	if (instr[25]) begin
		amt = 2 * instr[11:8];
		op2 = ({24'd0, instr[7:0]} >> amt) | ({24'd0, instr[7:0]} << (32 - amt));
		sc = (amt == 0) ? c : op2[31];
	end else begin
		amt = instr[11:7];
		case (shift_e'(instr[6:5]))
			SH_LSL: begin
				op2 = m << amt;
				sc = (amt == 0) ? c : m[32 - amt];
			end
			SH_ROR: if (amt == 0) begin
				op2 = {c, m[31:1]};
				sc = m[0];
			end else begin
				op2 = (m >> amt) | (m << (32 - amt));
				sc = op2[31];
			end
			default: begin // lsr and asr, #0 is #32
				if (amt == 0)
					amt = 32;
				if (instr[6])
					op2 = $signed(m) >>> amt;
				else
					op2 = m >> amt;
				sc = m[amt - 1];
			end
		endcase
	end
	x = a;
	y = op2;
	cin = 1'b0;
	arith = 1'b1;
	case (op)
		OP_SUB, OP_CMP: begin
			y = ~op2;
			cin = 1'b1;
		end
		OP_RSB, OP_RSC: begin
			x = op2;
			y = ~a;
			cin = (op == OP_RSB) ? 1'b1 : c;
		end
		OP_ADD, OP_CMN: cin = 1'b0;
		OP_ADC: cin = c;
		OP_SBC: begin
			y = ~op2;
			cin = c;
		end
		default: arith = 1'b0;
	endcase
	sum = {1'b0, x} + {1'b0, y} + cin;
	case (op)
		OP_AND, OP_TST: res = a & op2;
		OP_EOR, OP_TEQ: res = a ^ op2;
		OP_ORR: res = a | op2;
		OP_MOV: res = op2;
		OP_BIC: res = a & ~op2;
		OP_MVN: res = ~op2;
		default: res = sum[31:0];
	endcase
	if (instr[24:23] != 2'b10)
		st.r[rd] = res;
	if (instr[20] && rd != 4'd15)
		st.nzcv = {res[31], (res == 32'd0), arith ? sum[32] : sc,
			arith ? (x[31] == y[31]) && (sum[31] != x[31]) : st.nzcv[0]};
	return acc;
endfunction

`endif

// ==== verif/tb_arm_core.sv ====
`timescale 1ns/1ps

module tb_arm_core;
	import arm_pkg::*;

	`include "arm_ref_model.svh"

	localparam word_t RESET_PC = 32'h0800_0000; // core default
	localparam int CLK_PERIOD = 8;
	localparam int MAX_WAIT = 3;
	localparam int MARGIN = 200; // cycles
	localparam int N_TESTS = 5;
	localparam cond_t AL = 4'he;

	logic clk;
	logic rstn;
	word_t mem_addr, mem_wdata, mem_rdata;
	logic mem_read, mem_write, mem_ok;

	word_t mem [512];     // seen by the core
	word_t ref_mem [512]; // seen by the model
	int prog_len;
	int bnd [N_TESTS]; // fetch of this word closes the test
	string test_name [N_TESTS];
	int test_checks [N_TESTS];
	int test_errs [N_TESTS];
	int cur_test;
	logic done;

	ref_state_t st;
	ref_access_t acc;
	logic exp_data; // next transfer is the data access
	word_t exp_addr;

	logic [31:0] rng;
	logic busy;
	int wait_left;

	arm_core DUT (
		.clk      (clk),
		.rstn     (rstn),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_read (mem_read),
		.mem_write(mem_write),
		.mem_ok   (mem_ok)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int word_index(input word_t a);
		return int'(a[10:2]);
	endfunction

	function automatic word_t fill_word(input word_t a);
		return {a[15:0], a[31:16]} ^ 32'h5a3c_0f96 ^ (a >> 7);
	endfunction

	function automatic word_t bus_kind(input logic rd, input logic wr);
		return {30'd0, rd, wr};
	endfunction

	function automatic word_t dp_imm(input cond_t cc, input dp_op_e op, input logic s,
			input reg_idx_t rn, input reg_idx_t rd, input logic [3:0] rot, input logic [7:0] imm);
		return {cc, 3'b001, op, s, rn, rd, rot, imm};
	endfunction

	function automatic word_t dp_reg(input cond_t cc, input dp_op_e op, input logic s,
			input reg_idx_t rn, input reg_idx_t rd, input logic [4:0] amt, input shift_e sh,
			input reg_idx_t rm);
		return {cc, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
	endfunction

	function automatic word_t ldst(input cond_t cc, input logic pre, input logic up,
			input logic wb, input logic load, input reg_idx_t rn, input reg_idx_t rd,
			input logic [11:0] off);
		return {cc, 3'b010, pre, up, 1'b0, wb, load, rn, rd, off};
	endfunction

	function automatic word_t branch_to(input cond_t cc, input logic link, input int target);
		int off;
		off = target - (prog_len + 2);
		return {cc, 3'b101, link, 24'(off)};
	endfunction

	task automatic put(input word_t w);
		mem[prog_len] = w;
		ref_mem[prog_len] = w;
		prog_len++;
	endtask

	// one bit per condition code at bit 16 + cc, stored through r9
	task automatic flag_record();
		int cc;
		int p;
		put(dp_imm(AL, OP_MOV, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
		for (cc = 0; cc < 15; cc++) begin
			p = 16 + cc;
			put(dp_imm(cond_t'(cc), OP_ORR, 1'b0, 4'd0, 4'd0, 4'(((32 - p + p % 2) / 2) % 16),
				(p % 2 == 1) ? 8'd2 : 8'd1));
		end
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd9, 4'd0, 12'd4));
	endtask

	task automatic load_program();
		int i;
		int s;
		logic s_bit;
		for (i = 0; i < 512; i++) begin
			mem[i] = fill_word(RESET_PC + word_t'(4 * i));
			ref_mem[i] = mem[i];
		end
		prog_len = 0;
		bnd[0] = 0;
		put(dp_imm(AL, OP_ADD, 1'b0, 4'd15, 4'd8, 4'd15, 8'hfe)); // r8 = pc + 0x400
		put(dp_imm(AL, OP_ADD, 1'b0, 4'd8, 4'd9, 4'd12, 8'h01));  // r9 = r8 + 0x100
		put(dp_imm(AL, OP_MOV, 1'b0, 4'd0, 4'd1, 4'd2, 8'hff));   // 0xf000000f
		put(dp_imm(AL, OP_MOV, 1'b0, 4'd0, 4'd2, 4'd0, 8'h3c));
		put(dp_imm(AL, OP_MVN, 1'b0, 4'd0, 4'd3, 4'd0, 8'h00));
		// shifted register, first four use the #0 special cases
		for (i = 0; i < 16; i++) begin
			s_bit = (i >= 8 && i <= 11) || (i % 2 == 1);
			put(dp_reg(AL, dp_op_e'(i), s_bit, 4'd2, 4'd4, (i < 4) ? 5'd0 : 5'(i + 3),
				shift_e'(i % 4), 4'd1));
			put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd4, 12'd4));
		end
		for (i = 0; i < 16; i++) begin
			s_bit = (i >= 8 && i <= 11) || (i % 2 == 1);
			put(dp_imm(AL, dp_op_e'(i), s_bit, 4'd1, 4'd5, 4'(i), 8'(8'h81 ^ (i * 19))));
			put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd5, 12'd4));
		end
		bnd[1] = prog_len;
		put(dp_reg(AL, OP_CMP, 1'b1, 4'd1, 4'd0, 5'd0, SH_LSL, 4'd2));
		flag_record();
		put(dp_imm(AL, OP_ADD, 1'b1, 4'd3, 4'd6, 4'd0, 8'd1)); // wraps to zero
		flag_record();
		put(dp_imm(AL, OP_MOV, 1'b0, 4'd0, 4'd7, 4'd1, 8'd1));
		put(dp_reg(AL, OP_ADD, 1'b1, 4'd7, 4'd7, 5'd0, SH_LSL, 4'd7)); // signed overflow
		flag_record();
		put(dp_reg(AL, OP_MOV, 1'b1, 4'd0, 4'd6, 5'd0, SH_LSR, 4'd1));
		flag_record();
		put(dp_reg(AL, OP_SBC, 1'b1, 4'd2, 4'd6, 5'd0, SH_ROR, 4'd1));
		flag_record();
		bnd[2] = prog_len;
		s = prog_len;
		put(dp_imm(AL, OP_CMP, 1'b1, 4'd2, 4'd0, 4'd0, 8'h3c));
		put(branch_to(4'h1, 1'b0, s + 3)); // not taken
		put(branch_to(AL, 1'b0, s + 4));
		put(dp_imm(AL, OP_MOV, 1'b0, 4'd0, 4'd2, 4'd0, 8'h77));
		put(branch_to(4'h0, 1'b0, s + 6));
		put(dp_imm(AL, OP_MOV, 1'b0, 4'd0, 4'd2, 4'd0, 8'h99));
		put(branch_to(AL, 1'b1, s + 10));
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd14, 12'd4)); // link value
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd10, 12'd4));
		put(branch_to(AL, 1'b0, s + 12));
		put(dp_imm(AL, OP_ADD, 1'b0, 4'd2, 4'd10, 4'd0, 8'd5)); // subroutine
		put(dp_reg(AL, OP_MOV, 1'b0, 4'd0, 4'd15, 5'd0, SH_LSL, 4'd14));
		bnd[3] = prog_len;
		put(dp_imm(AL, OP_ADD, 1'b0, 4'd9, 4'd11, 4'd12, 8'h02)); // r11 = r9 + 0x200
		put(ldst(AL, 1'b1, 1'b1, 1'b0, 1'b1, 4'd11, 4'd12, 12'd8));
		put(ldst(AL, 1'b1, 1'b0, 1'b1, 1'b0, 4'd11, 4'd12, 12'd4));
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b1, 4'd11, 4'd13, 12'd12));
		put(ldst(AL, 1'b0, 1'b0, 1'b0, 1'b0, 4'd11, 4'd13, 12'd8));
		put(ldst(AL, 1'b1, 1'b1, 1'b1, 1'b1, 4'd11, 4'd0, 12'd16));
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd11, 12'd4));
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd0, 12'd4));
		put(ldst(AL, 1'b1, 1'b0, 1'b1, 1'b1, 4'd11, 4'd11, 12'd16)); // load beats write-back
		put(ldst(AL, 1'b0, 1'b1, 1'b0, 1'b0, 4'd8, 4'd11, 12'd4));
		put(ldst(AL, 1'b1, 1'b1, 1'b0, 1'b0, 4'd8, 4'd12, 12'd4));
		bnd[4] = prog_len;
		put(branch_to(AL, 1'b0, prog_len)); // final loop
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		test_checks[cur_test]++;
		if (got !== exp) begin
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
			test_errs[cur_test]++;
		end
	endtask

	task automatic check_flags(input flags_t got, input flags_t exp);
		test_checks[cur_test]++;
		if (got !== exp) begin
			$display("FAILED %0t: flags NZCV are %b, expected %b", $time, got, exp);
			test_errs[cur_test]++;
		end
	endtask

	task automatic close_test();
		$display("test %0d %s: %0d checks, %0d errors", cur_test + 1, test_name[cur_test],
			test_checks[cur_test], test_errs[cur_test]);
		cur_test++;
	endtask

	task automatic finish_transfer();
		ref_state_t probe;
		word_t ins;
		int idx;
		if (exp_data) begin
			if (acc.wr) begin
				check_word("store data", mem_wdata, acc.wdata);
				// records hold EQ, CS, MI and VS at bits 16, 18, 20 and 22
				if ((acc.addr - RESET_PC) inside {[32'h500 : 32'h5ff]})
					check_flags({mem_wdata[20], mem_wdata[16], mem_wdata[18], mem_wdata[22]},
						st.nzcv);
				ref_mem[word_index(acc.addr)] = acc.wdata;
			end
			exp_data = 1'b0;
			exp_addr = st.r[15];
		end else begin
			idx = word_index(st.r[15]);
			while (cur_test < N_TESTS && idx >= bnd[cur_test])
				close_test();
			if (cur_test == N_TESTS) begin
				done = 1'b1;
			end else begin
				ins = ref_mem[idx];
				probe = st;
				acc = ref_step(probe, ins, 32'd0); // only for the address
				acc = ref_step(st, ins, ref_mem[word_index(acc.addr)]);
				exp_data = acc.rd || acc.wr;
				exp_addr = exp_data ? acc.addr : st.r[15];
			end
		end
	endtask

	// memory: 0 to 3 wait states per request
	always @(posedge clk) begin
		#1;
		if (mem_ok)
			busy = 1'b0;
		mem_ok = 1'b0;
		if ((mem_read || mem_write) && !busy) begin
			busy = 1'b1;
			rng = xorshift(rng);
			wait_left = int'(rng[1:0]);
		end
		if (busy) begin
			if (wait_left == 0)
				mem_ok = 1'b1;
			else
				wait_left--;
		end
		mem_rdata = mem[word_index(mem_addr)];
	end

	always @(negedge clk) begin
		if (mem_ok && mem_write)
			mem[word_index(mem_addr)] = mem_wdata;
	end

	// checks every request cycle, so a waiting request must hold still
	always @(negedge clk) begin
		if (!rstn) begin
			test_checks[0]++;
			if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
				$display("FAILED %0t: bus request while reset is low", $time);
				test_errs[0]++;
			end
		end else if (!done && (mem_read || mem_write)) begin
			if (exp_data) begin
				check_word("data address", mem_addr, exp_addr);
				check_word("bus direction", bus_kind(mem_read, mem_write),
					bus_kind(acc.rd, acc.wr));
			end else begin
				check_word("fetch address", mem_addr, exp_addr);
				check_word("bus direction", bus_kind(mem_read, mem_write), bus_kind(1'b1, 1'b0));
			end
			if (mem_ok)
				finish_transfer();
		end
	end

	initial begin
		int i;
		int total_checks;
		int total_errs;
		rstn = 1'b0;
		mem_ok = 1'b0;
		mem_rdata = '0;
		busy = 1'b0;
		wait_left = 0;
		rng = 32'd84291;
		done = 1'b0;
		cur_test = 0;
		total_checks = 0;
		total_errs = 0;
		test_name = '{"reset and first fetch", "data processing", "flags and conditions",
			"branch and link", "load and store"};
		for (i = 0; i < N_TESTS; i++) begin
			test_checks[i] = 0;
			test_errs[i] = 0;
		end
		load_program();
		for (i = 0; i < 16; i++)
			st.r[i] = '0;
		st.r[15] = RESET_PC;
		st.nzcv = '0;
		exp_data = 1'b0;
		exp_addr = RESET_PC;
		repeat (16) @(posedge clk);
		#1 rstn = 1'b1;
		wait (done);
		@(posedge clk);
		for (i = 0; i < N_TESTS; i++) begin
			total_checks += test_checks[i];
			total_errs += test_errs[i];
		end
		$display("%0d tests, %0d checks, %0d errors", N_TESTS, total_checks, total_errs);
		if (total_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// each instruction needs at most two transfers plus execute
	initial begin
		longint limit;
		@(posedge rstn);
		limit = (longint'(prog_len) * 4 * (MAX_WAIT + 1) + MARGIN) * CLK_PERIOD;
		#(limit);
		$display("timeout: the core did not reach the final loop of the program");
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
design/arm_pkg.sv
design/arm_shifter_alu.sv
design/arm_execute.sv
design/arm_regfile.sv
design/arm_sequencer.sv
design/arm_core.sv
verif/tb_arm_core.sv

// ==== Bender.yml ====
package:
  name: arm_core

sources:
  - files:
      - design/arm_pkg.sv
      - design/arm_shifter_alu.sv
      - design/arm_execute.sv
      - design/arm_regfile.sv
      - design/arm_sequencer.sv
      - design/arm_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_arm_core.sv
